//--- flist.f
design/vector_pkg.sv
design/sync_fifo.sv
design/issue_fsm.sv
design/beat_counter.sv
design/vector_regfile.sv
design/lane_alu.sv
design/vector_backend.sv
tb/backend_props.sv
tb/tb_vector_backend.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_vector_backend
FLIST = flist.f
OBJ_DIR = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_vector_backend.sv
`timescale 1ns/1ps

module tb_vector_backend import vector_pkg::*; ();

    localparam int WAIT_LIMIT = 500;

    typedef struct packed {
        logic [2:0]  test;
        vector_cmd_t cmd;
        xrf_wr_t     exp;
    } stim_t;

    logic clk;
    logic rst_n;
    logic cmd_valid;
    vector_cmd_t cmd;
    logic cmd_ready;
    logic xrf_valid;
    xrf_wr_t xrf_wr;
    logic xrf_ready;

    stim_t table_q[$];
    xrf_wr_t exp_q[$];
    logic [ELEN_W-1:0] vmodel [NUM_VREGS][VLEN/ELEN_W];
    int errors;
    int failed;
    int sent;

    vector_backend DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .xrf_valid (xrf_valid),
        .xrf_wr    (xrf_wr),
        .xrf_ready (xrf_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reference model, whole registers executed in order
    function automatic logic [ELEN_W-1:0] model_exec(input vector_cmd_t c);
        logic [ELEN_W-1:0] sum;
        sum = vmodel[c.vs1][0];
        for (int i = 0; i < VLEN / ELEN_W; i++) begin
            case (c.op)
                VADD_VV: vmodel[c.vd][i] = vmodel[c.vs1][i] + vmodel[c.vs2][i];
                VMV_VX: vmodel[c.vd][i] = c.scalar;
                default: sum = sum + vmodel[c.vs2][i];
            endcase
        end
        return sum;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "reset";
            2: return "broadcast then reduce";
            3: return "add then reduce";
            4: return "result back-pressure";
            default: return "random mix";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic end_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic add_row(input int test, input vector_op_e op, input int vd,
                           input int vs1, input int vs2, input logic [ELEN_W-1:0] s);
        stim_t row;
        row.test = 3'(test);
        row.cmd.op = op;
        row.cmd.vd = reg_idx_t'(vd);
        row.cmd.vs1 = reg_idx_t'(vs1);
        row.cmd.vs2 = reg_idx_t'(vs2);
        row.cmd.scalar = s;
        row.exp.rd = row.cmd.vd;
        row.exp.data = XLEN'(model_exec(row.cmd));
        table_q.push_back(row);
    endtask

    task automatic build_table();
        logic [ELEN_W-1:0] a;
        logic [ELEN_W-1:0] b;
        for (int r = 0; r < NUM_VREGS; r++) begin
            for (int e = 0; e < VLEN / ELEN_W; e++) begin
                vmodel[r][e] = '0;
            end
        end
        a = 8'($urandom);
        add_row(2, VMV_VX, 4, 0, 0, a);
        add_row(2, VREDSUM_VS, 7, 0, 4, '0);
        a = 8'($urandom);
        b = 8'($urandom);
        add_row(3, VMV_VX, 1, 0, 0, a);
        add_row(3, VMV_VX, 2, 0, 0, b);
        add_row(3, VADD_VV, 3, 1, 2, '0);
        add_row(3, VREDSUM_VS, 9, 1, 3, '0);
        // More reductions than the two queues and the FSM can hold
        for (int i = 0; i < 10; i++) begin
            add_row(4, VREDSUM_VS, 10 + i, i % 4, 1 + i % 3, '0);
        end
        // Small index range so vd often aliases a source
        for (int i = 0; i < 24; i++) begin
            add_row(5, vector_op_e'(2'($urandom % 3)), int'($urandom % 8),
                    int'($urandom % 8), int'($urandom % 8), 8'($urandom));
        end
    endtask

    task automatic send_cmd(input vector_cmd_t c);
        int waited;
        waited = 0;
        cmd_valid = 1'b1;
        cmd = c;
        @(negedge clk);
        while (!cmd_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) end_on_timeout("cmd_ready stayed low");
            @(negedge clk);
        end
        sent++;
        next_drive_slot();
    endtask

    task automatic run_rows(input int t);
        sent = 0;
        foreach (table_q[i]) begin
            if (table_q[i].test == 3'(t)) begin
                if (table_q[i].cmd.op == VREDSUM_VS) exp_q.push_back(table_q[i].exp);
                send_cmd(table_q[i].cmd);
            end
        end
        cmd_valid = 1'b0;
    endtask

    task automatic release_after_stall();
        int waited;
        waited = 0;
        @(negedge clk);
        // Full result queue, one reduction in the FSM, full command queue
        while ((sent < CMDQ_DEPTH + RESQ_DEPTH + 1 || cmd_ready) && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        assert (!cmd_ready && sent == CMDQ_DEPTH + RESQ_DEPTH + 1) else begin
            $display("cmd_ready did not fall with the result queue blocked");
            errors++;
        end
        // Stalled reduction keeps further commands out
        repeat (2 * NUM_BEATS) begin
            @(negedge clk);
            assert (!cmd_ready) else begin
                $display("cmd_ready rose while xrf_ready was held low");
                errors++;
            end
        end
        next_drive_slot();
        xrf_ready = 1'b1;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            waited++;
            if (waited > WAIT_LIMIT) end_on_timeout("reduction results did not all arrive");
            @(negedge clk);
        end
    endtask

    task automatic report_test(input int t, input int errs);
        if (errs == 0) begin
            $display("Test %0d (%s): ok", t, test_name(t));
        end else begin
            $display("Test %0d (%s): %0d errors", t, test_name(t), errs);
            failed++;
        end
    endtask

    // Handshake seen here completes on the next rising edge
    always @(negedge clk) begin : result_monitor
        xrf_wr_t want;
        if (rst_n && xrf_valid && xrf_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("Result for rd %0d arrived with no reduction outstanding", xrf_wr.rd);
                errors++;
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                compare_value("xrf_wr.rd", 32'(xrf_wr.rd), 32'(want.rd));
                compare_value("xrf_wr.data", xrf_wr.data, want.data);
            end
        end
    end

    initial begin
        int start_errors;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        xrf_ready = 1'b1;
        errors = 0;
        failed = 0;
        sent = 0;
        void'($urandom(32'h0065f0c0));
        build_table();

        repeat (10) begin
            next_drive_slot();
            compare_value("xrf_valid", 32'(xrf_valid), 32'd0);
        end
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("xrf_valid", 32'(xrf_valid), 32'd0);
        compare_value("cmd_ready", 32'(cmd_ready), 32'd1);
        report_test(1, errors);

        for (int t = 2; t <= 5; t++) begin
            start_errors = errors;
            next_drive_slot();
            if (t == 4) begin
                xrf_ready = 1'b0;
                fork
                    run_rows(t);
                    release_after_stall();
                join
            end else begin
                run_rows(t);
            end
            wait_results();
            report_test(t, errors - start_errors);
        end

        $display("Tests run: 5, failed: %0d, errors: %0d", failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb/backend_props.sv
`timescale 1ns/1ps

module backend_props import vector_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    cmd_ready,
    input logic    cmdq_pop,
    input logic    xrf_valid,
    input xrf_wr_t xrf_wr,
    input logic    xrf_ready
);

    // Result queue is empty once a reset edge has passed
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !xrf_valid)
        else $error("xrf_valid high after a reset cycle");

    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        xrf_valid && !xrf_ready |=> xrf_valid && $stable(xrf_wr))
        else $error("Stalled result changed or dropped");

    // While full, only a pop may free a slot
    full_no_take: assert property (@(posedge clk) disable iff (!rst_n)
        !cmd_ready |=> (cmd_ready == $past(cmdq_pop)))
        else $error("Command queue changed occupancy while cmd_ready was low");

endmodule

bind vector_backend backend_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_ready (cmd_ready),
    .cmdq_pop  (cmdq_pop),
    .xrf_valid (xrf_valid),
    .xrf_wr    (xrf_wr),
    .xrf_ready (xrf_ready)
);

//--- design/vector_backend.sv
`timescale 1ns/1ps

module vector_backend import vector_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  vector_cmd_t cmd,
    output logic        cmd_ready,
    output logic        xrf_valid,
    output xrf_wr_t     xrf_wr,
    input  logic        xrf_ready
);

    logic cmdq_full;
    logic cmdq_empty;
    logic cmdq_pop;
    vector_cmd_t cmd_head;

    logic resq_full;
    logic resq_empty;
    logic res_push;
    xrf_wr_t res_data;

    logic beat_start;
    logic beat_en;
    logic last;
    beat_idx_t beat;

    vector_op_e op;
    logic [ELEN_W-1:0] scalar;
    logic [ELEN_W-1:0] red_sum;
    reg_idx_t rd_idx1;
    reg_idx_t rd_idx2;
    reg_idx_t wr_idx;
    logic wr_en;
    chunk_t src1;
    chunk_t src2;
    chunk_t wr_chunk;

    assign cmd_ready = !cmdq_full;
    assign xrf_valid = !resq_empty;

    sync_fifo #(
        .T     (vector_cmd_t),
        .DEPTH (CMDQ_DEPTH)
    ) u_cmd_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (cmd_valid && cmd_ready),
        .wdata (cmd),
        .pop   (cmdq_pop),
        .rdata (cmd_head),
        .full  (cmdq_full),
        .empty (cmdq_empty)
    );

    issue_fsm u_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_empty  (cmdq_empty),
        .cmd_head   (cmd_head),
        .cmd_pop    (cmdq_pop),
        .last       (last),
        .beat_start (beat_start),
        .beat_en    (beat_en),
        .op         (op),
        .scalar     (scalar),
        .rd_idx1    (rd_idx1),
        .rd_idx2    (rd_idx2),
        .wr_idx     (wr_idx),
        .wr_en      (wr_en),
        .red_sum    (red_sum),
        .res_full   (resq_full),
        .res_push   (res_push),
        .res_data   (res_data)
    );

    beat_counter u_beat (
        .clk   (clk),
        .rst_n (rst_n),
        .start (beat_start),
        .beat  (beat),
        .last  (last)
    );

    vector_regfile u_vrf (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat      (beat),
        .rd_idx1   (rd_idx1),
        .rd_idx2   (rd_idx2),
        .rd_chunk1 (src1),
        .rd_chunk2 (src2),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_chunk  (wr_chunk)
    );

    lane_alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .beat_en (beat_en),
        .beat    (beat),
        .op      (op),
        .scalar  (scalar),
        .src1    (src1),
        .src2    (src2),
        .result  (wr_chunk),
        .red_sum (red_sum)
    );

    // Scalar results back to the XRF
    sync_fifo #(
        .T     (xrf_wr_t),
        .DEPTH (RESQ_DEPTH)
    ) u_res_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (res_push),
        .wdata (res_data),
        .pop   (xrf_valid && xrf_ready),
        .rdata (xrf_wr),
        .full  (resq_full),
        .empty (resq_empty)
    );

endmodule

//--- design/lane_alu.sv
`timescale 1ns/1ps

module lane_alu import vector_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              beat_en,
    input  beat_idx_t         beat,
    input  vector_op_e        op,
    input  logic [ELEN_W-1:0] scalar,
    input  chunk_t            src1,
    input  chunk_t            src2,
    output chunk_t            result,
    output logic [ELEN_W-1:0] red_sum
);

    logic [ELEN_W-1:0] chunk_sum;
    logic [ELEN_W-1:0] acc;

    // Per-lane result for the element-wise ops
    always_comb begin
        result = src2;
        for (int i = 0; i < LANES; i++) begin
            case (op)
                VADD_VV: result[i] = src1[i] + src2[i];
                VMV_VX: result[i] = scalar;
                default: result[i] = src2[i];
            endcase
        end
    end

    // Sum of the four bytes of vs2, wrapping at 8 bits
    always_comb begin
        chunk_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            chunk_sum = chunk_sum + src2[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (beat_en && op == VREDSUM_VS) begin
            // Seed with vs1[0] on the first chunk
            if (beat == '0) begin
                acc <= src1[0] + chunk_sum;
            end else begin
                acc <= acc + chunk_sum;
            end
        end
    end

    assign red_sum = acc;

endmodule

//--- design/vector_regfile.sv
`timescale 1ns/1ps

module vector_regfile import vector_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  beat_idx_t beat,
    input  reg_idx_t  rd_idx1,
    input  reg_idx_t  rd_idx2,
    output chunk_t    rd_chunk1,
    output chunk_t    rd_chunk2,
    input  logic      wr_en,
    input  reg_idx_t  wr_idx,
    input  chunk_t    wr_chunk
);

    logic [VLEN-1:0] vregs [NUM_VREGS];

    // Chunk selected by the current beat
    assign rd_chunk1 = vregs[rd_idx1][beat * (LANES * ELEN_W) +: LANES * ELEN_W];
    assign rd_chunk2 = vregs[rd_idx2][beat * (LANES * ELEN_W) +: LANES * ELEN_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VREGS; i++) begin
                vregs[i] <= '0;
            end
        end else if (wr_en) begin
            vregs[wr_idx][beat * (LANES * ELEN_W) +: LANES * ELEN_W] <= wr_chunk;
        end
    end

endmodule

//--- design/beat_counter.sv
`timescale 1ns/1ps

module beat_counter import vector_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    output beat_idx_t beat,
    output logic      last
);

    logic running;

    assign last = running && (beat == beat_idx_t'(NUM_BEATS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat <= '0;
            running <= 1'b0;
        end else if (start) begin
            beat <= '0;
            running <= 1'b1;
        end else if (running) begin
            // Stop on the final chunk
            if (last) begin
                running <= 1'b0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

endmodule

//--- design/issue_fsm.sv
`timescale 1ns/1ps

module issue_fsm import vector_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_empty,
    input  vector_cmd_t       cmd_head,
    output logic              cmd_pop,
    input  logic              last,
    output logic              beat_start,
    output logic              beat_en,
    output vector_op_e        op,
    output logic [ELEN_W-1:0] scalar,
    output reg_idx_t          rd_idx1,
    output reg_idx_t          rd_idx2,
    output reg_idx_t          wr_idx,
    output logic              wr_en,
    input  logic [ELEN_W-1:0] red_sum,
    input  logic              res_full,
    output logic              res_push,
    output xrf_wr_t           res_data
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        REPORT
    } state_e;

    state_e state;
    state_e state_nxt;
    vector_cmd_t cur;
    logic is_red;

    assign is_red = (cur.op == VREDSUM_VS);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (!cmd_empty) state_nxt = EXEC;
            EXEC: if (last) state_nxt = is_red ? REPORT : IDLE;
            // Wait here while the result queue is full
            REPORT: if (!res_full) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            cur <= cmd_head;
        end
    end

    assign cmd_pop = (state == IDLE) && !cmd_empty;
    assign beat_start = cmd_pop;
    assign beat_en = (state == EXEC);

    assign op = cur.op;
    assign scalar = cur.scalar;
    assign rd_idx1 = cur.vs1;
    assign rd_idx2 = cur.vs2;
    assign wr_idx = cur.vd;
    // Reductions leave the VRF untouched
    assign wr_en = beat_en && !is_red;

    assign res_push = (state == REPORT) && !res_full;
    assign res_data.rd = cur.vd;
    assign res_data.data = XLEN'(red_sum);

endmodule

//--- design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo import vector_pkg::*; #(
    parameter type T = vector_cmd_t,
    parameter int DEPTH = CMDQ_DEPTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,
    output logic full,
    output logic empty
);

    T mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] rptr;
    logic [$clog2(DEPTH)-1:0] wptr;
    logic [$clog2(DEPTH):0] count;
    logic do_push;
    logic do_pop;

    // Requests beyond the current occupancy are dropped
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rptr <= '0;
            wptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= (wptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= (rptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry, shown without a register stage
    assign rdata = mem[rptr];
    assign full = (count == ($clog2(DEPTH) + 1)'(DEPTH));
    assign empty = (count == '0);

endmodule

//--- design/vector_pkg.sv
package vector_pkg;

    localparam int VLEN = 128;
    localparam int ELEN_W = 8;
    localparam int LANES = 4;
    localparam int NUM_BEATS = VLEN / (LANES * ELEN_W);
    localparam int XLEN = 32;
    localparam int NUM_VREGS = 32;
    localparam int CMDQ_DEPTH = 4;
    localparam int RESQ_DEPTH = 4;

    typedef logic [$clog2(NUM_VREGS)-1:0] reg_idx_t;
    typedef logic [$clog2(NUM_BEATS)-1:0] beat_idx_t;

    // Four byte elements, lane 0 in the low byte
    typedef logic [LANES-1:0][ELEN_W-1:0] chunk_t;

    typedef enum logic [1:0] {
        VADD_VV    = 2'd0,
        VMV_VX     = 2'd1,
        VREDSUM_VS = 2'd2
    } vector_op_e;

    // vd doubles as the scalar rd for a reduction
    typedef struct packed {
        vector_op_e        op;
        reg_idx_t          vd;
        reg_idx_t          vs1;
        reg_idx_t          vs2;
        logic [ELEN_W-1:0] scalar;
    } vector_cmd_t;

    typedef struct packed {
        reg_idx_t          rd;
        logic [XLEN-1:0]   data;
    } xrf_wr_t;

endpackage
